/* riscv_core.f */
rv_isa_pkg.sv
rv_core_pkg.sv
reg_file.sv
insn_decoder.sv
alu.sv
fetch_control.sv
riscv_core.sv
riscv_core_properties.sv
riscv_core_tb.sv

/* Bender.yml */
package:
  name: riscv_core

sources:
  - rv_isa_pkg.sv
  - rv_core_pkg.sv
  - reg_file.sv
  - insn_decoder.sv
  - alu.sv
  - fetch_control.sv
  - riscv_core.sv
  - target: test
    files:
      - riscv_core_properties.sv
      - riscv_core_tb.sv

/* riscv_core_tb.sv */
`timescale 1ns/1ps

module riscv_core_tb import rv_isa_pkg::*; ();

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 2;
  localparam int          NUM_TESTS    = 6;
  localparam int          BUDGET       = 200; // Cycles allowed per program
  localparam int          EXTRA_CYCLES = 20;  // Idle cycles watched after halt
  localparam int          MARGIN_NS    = 500;
  localparam int          WATCHDOG_NS  =
    (NUM_TESTS * (BUDGET + RESET_CYCLES + 2) + EXTRA_CYCLES) * CLK_PERIOD + MARGIN_NS;
  localparam int          MEM_WORDS    = 1024;
  localparam logic [31:0] RESET_PC     = 32'h0000_0100;
  localparam logic [31:0] DATA_BASE    = 32'h0000_0800; // Kept in x10

  logic        clk;
  logic        rst;
  logic [31:0] pc, insn, dmem_addr, dmem_wdata, dmem_rdata;
  logic        dmem_we, halt;

  logic [31:0] mem [0:MEM_WORDS-1];
  logic [31:0] st_addr[$], st_data[$];   // Stores taken at clock edges
  logic [31:0] exp_addr[$], exp_data[$];
  logic [31:0] load_pc;                  // Next free program address
  logic [31:0] halt_pc;                  // Address of the closing ECALL
  int          store_off;
  int          errors;

  riscv_core #(.RESET_PC(RESET_PC)) riscv_core_i (
    .clk(clk), .rst(rst), .pc(pc), .insn(insn),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
    .dmem_we(dmem_we), .halt(halt)
  );

  bind riscv_core riscv_core_properties riscv_core_properties_i (
    .clk(clk), .rst(rst), .pc(pc), .dmem_we(dmem_we), .halt(halt)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Instruction and data memory read combinationally
  assign insn       = mem[pc[11:2]];
  assign dmem_rdata = mem[dmem_addr[11:2]];

  always @(posedge clk) begin
    if (!rst && dmem_we) begin
      mem[dmem_addr[11:2]] <= dmem_wdata;
      st_addr.push_back(dmem_addr);
      st_data.push_back(dmem_wdata);
    end
  end

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return ~addr ^ {addr[15:0] ^ 16'hA5C3, addr[31:16]};
  endfunction

  function automatic int word_index(input logic [31:0] addr);
    return int'(addr[11:2]);
  endfunction

  // Instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] i_type(input opcode_e op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input opcode_e op, input logic [4:0] rd,
                                         input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // Branch rule of the ISA
  function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic stop_on_failure();
    errors++;
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic put(input logic [31:0] word);
    mem[word_index(load_pc)] <= word;
    load_pc = load_pc + 32'd4;
  endtask

  // LUI plus ADDI in two words
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = (value + 32'h800) >> 12;
    put(u_type(OP_LUI, rd, hi[19:0]));
    put(i_type(OP_IMM, F3_ADD, rd, rd, value[11:0]));
  endtask

  task automatic store_word(input logic [4:0] rs, input bit expect_it,
                            input logic [31:0] value);
    put(s_type(12'(store_off), rs, 10));
    if (expect_it) begin
      exp_addr.push_back(DATA_BASE + 32'(store_off));
      exp_data.push_back(value);
    end
    store_off += 4;
  endtask

  task automatic compute_and_store(input logic [31:0] word, input logic [31:0] value);
    put(word);
    store_word(3, 1'b1, value); // Results always land in x3
  endtask

  task automatic emit_ecall();
    halt_pc = load_pc;
    put(i_type(OP_SYSTEM, 3'b000, 0, 0, 12'd0));
  endtask

  task automatic begin_test();
    @(posedge clk);
    rst <= 1'b1;
    st_addr.delete();
    st_data.delete();
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] <= fill_word(32'(i) << 2);
    end
    load_pc   = RESET_PC;
    store_off = 0;
    load_const(10, DATA_BASE);
  endtask

  task automatic release_reset(input string name);
    @(posedge clk);
    @(negedge clk);
    check_value({name, " pc in reset"}, RESET_PC, pc);
    check_value({name, " halt in reset"}, 32'd0, {31'b0, halt});
    check_value({name, " dmem_we in reset"}, 32'd0, {31'b0, dmem_we});
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value({name, " pc after reset"}, RESET_PC, pc);
    check_value({name, " halt after reset"}, 32'd0, {31'b0, halt});
    check_value({name, " dmem_we after reset"}, 32'd0, {31'b0, dmem_we});
  endtask

  task automatic run_until_halt(input string name);
    int cycles;
    cycles = 0;
    while (!halt) begin
      @(negedge clk);
      cycles++;
      if (cycles > BUDGET) begin
        $display("ERROR: %s program did not halt within %0d cycles", name, BUDGET);
        stop_on_failure();
      end
    end
    check_value({name, " pc at halt"}, halt_pc, pc);
  endtask

  task automatic check_stores(input string name);
    check_value({name, " store count"}, 32'(exp_addr.size()), 32'(st_addr.size()));
    for (int k = 0; k < exp_addr.size(); k++) begin
      check_value($sformatf("%s store %0d addr", name, k), exp_addr[k], st_addr[k]);
      check_value($sformatf("%s store %0d data", name, k), exp_data[k], st_data[k]);
    end
  endtask

  task automatic run_program(input string name);
    release_reset(name);
    run_until_halt(name);
    check_stores(name);
  endtask

  task automatic check_reset();
    logic [31:0] v;
    begin_test();
    v = $urandom() & 32'h7FF;
    put(i_type(OP_IMM, F3_ADD, 1, 0, v[11:0]));
    store_word(1, 1'b1, v);
    emit_ecall();
    run_program("reset");
  endtask

  task automatic alu_ops();
    logic [31:0] a, b, r, imm_x;
    logic [11:0] imm;
    logic [4:0]  sh;
    begin_test();
    a     = $urandom();
    r     = $urandom();
    b     = {~a[31], r[30:0]}; // Opposite signs so SLT and SLTU disagree
    imm   = 12'($urandom());
    imm_x = {{20{imm[11]}}, imm};
    sh    = 5'($urandom());
    load_const(1, a);
    load_const(2, b);
    compute_and_store(r_type(FUNCT7_BASE, 2, 1, F3_ADD, 3), a + b);
    compute_and_store(r_type(FUNCT7_ALT, 2, 1, F3_ADD, 3), a - b);
    compute_and_store(r_type(FUNCT7_BASE, 2, 1, F3_SLL, 3), a << b[4:0]);
    compute_and_store(r_type(FUNCT7_BASE, 2, 1, F3_SLT, 3), 32'($signed(a) < $signed(b)));
    compute_and_store(r_type(FUNCT7_BASE, 2, 1, F3_SLTU, 3), 32'(a < b));
    compute_and_store(r_type(FUNCT7_BASE, 2, 1, F3_XOR, 3), a ^ b);
    compute_and_store(r_type(FUNCT7_BASE, 2, 1, F3_SR, 3), a >> b[4:0]);
    compute_and_store(r_type(FUNCT7_ALT, 2, 1, F3_SR, 3), 32'($signed(a) >>> b[4:0]));
    compute_and_store(r_type(FUNCT7_BASE, 2, 1, F3_OR, 3), a | b);
    compute_and_store(r_type(FUNCT7_BASE, 2, 1, F3_AND, 3), a & b);
    // Immediate forms
    compute_and_store(i_type(OP_IMM, F3_ADD, 3, 1, imm), a + imm_x);
    compute_and_store(i_type(OP_IMM, F3_SLT, 3, 1, imm), 32'($signed(a) < $signed(imm_x)));
    compute_and_store(i_type(OP_IMM, F3_SLTU, 3, 1, imm), 32'(a < imm_x));
    compute_and_store(i_type(OP_IMM, F3_XOR, 3, 1, imm), a ^ imm_x);
    compute_and_store(i_type(OP_IMM, F3_OR, 3, 1, imm), a | imm_x);
    compute_and_store(i_type(OP_IMM, F3_AND, 3, 1, imm), a & imm_x);
    compute_and_store(i_type(OP_IMM, F3_SLL, 3, 1, {FUNCT7_BASE, sh}), a << sh);
    compute_and_store(i_type(OP_IMM, F3_SR, 3, 1, {FUNCT7_BASE, sh}), a >> sh);
    compute_and_store(i_type(OP_IMM, F3_SR, 3, 1, {FUNCT7_ALT, sh}), 32'($signed(a) >>> sh));
    emit_ecall();
    run_program("alu");
  endtask

  task automatic branch_compares();
    logic [31:0] p, marker;
    logic [31:0] pa [5];
    logic [31:0] pb [5];
    logic [2:0]  f3s [6];
    begin_test();
    p      = $urandom() & 32'h3FFF_FFFF;
    marker = $urandom();
    pa     = '{p, p, p + 1, p | 32'h8000_0000, p};
    pb     = '{p, p + 1, p, p, p | 32'h8000_0000};
    f3s    = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    load_const(5, marker);
    for (int k = 0; k < 5; k++) begin
      load_const(1, pa[k]);
      load_const(2, pb[k]);
      for (int j = 0; j < 6; j++) begin
        put(b_type(f3s[j], 1, 2, 13'd8)); // Taken skips the marker
        store_word(5, !branch_taken(f3s[j], pa[k], pb[k]), marker);
      end
    end
    emit_ecall();
    run_program("branches");
  endtask

  task automatic jumps_and_links();
    logic [31:0] marker, jal_at, jalr_at, target, auipc_at, u;
    begin_test();
    marker = $urandom();
    u      = $urandom();
    load_const(5, marker);
    jal_at = load_pc;
    put(j_type(6, 21'd8));
    store_word(5, 1'b0, marker);
    store_word(6, 1'b1, jal_at + 32'd4);
    jalr_at = load_pc + 32'd8;
    target  = jalr_at + 32'd8;
    load_const(7, target - 32'd3); // Odd sum that JALR rounds down
    put(i_type(OP_JALR, F3_JALR, 8, 7, 12'd4));
    store_word(5, 1'b0, marker);
    store_word(8, 1'b1, jalr_at + 32'd4);
    auipc_at = load_pc;
    put(u_type(OP_AUIPC, 9, u[19:0]));
    store_word(9, 1'b1, auipc_at + {u[19:0], 12'b0});
    emit_ecall();
    run_program("jumps");
  endtask

  task automatic load_and_x0();
    logic [31:0] word, u;
    begin_test();
    word = $urandom();
    u    = $urandom();
    mem[word_index(DATA_BASE + 32'h100)] <= word; // Overrides the fill
    put(i_type(OP_LOAD, F3_WORD, 11, 10, 12'h100));
    store_word(11, 1'b1, word);
    put(i_type(OP_IMM, F3_ADD, 0, 0, 12'h35A));
    put(u_type(OP_LUI, 0, u[19:0]));
    store_word(0, 1'b1, 32'd0);
    emit_ecall();
    run_program("load_x0");
  endtask

  task automatic halt_holds();
    logic [31:0] v;
    begin_test();
    v = $urandom();
    load_const(1, v);
    store_word(1, 1'b1, v);
    emit_ecall();
    store_word(1, 1'b0, v); // Past the ECALL
    run_program("halt");
    @(posedge clk);
    mem[word_index(halt_pc)] <= s_type(12'd4, 1, 10); // A store under the frozen pc
    repeat (EXTRA_CYCLES) begin
      @(negedge clk);
      check_value("halt pc held", halt_pc, pc);
      check_value("halt level", 32'd1, {31'b0, halt});
      check_value("halt dmem_we", 32'd0, {31'b0, dmem_we});
    end
    check_stores("halt idle");
    check_value("halt stored word", v, mem[word_index(DATA_BASE)]);
    check_value("halt word untouched", fill_word(DATA_BASE + 32'd4),
                mem[word_index(DATA_BASE + 32'd4)]);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, a test is stuck", WATCHDOG_NS);
    stop_on_failure();
  end

  initial begin
    void'($urandom(28));
    errors = 0;
    rst    = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(32'(i) << 2);
    end
    check_reset();
    alu_ops();
    branch_compares();
    jumps_and_links();
    load_and_x0();
    halt_holds();
    if (errors == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "errors were found");
    end
  end

endmodule

/* riscv_core_properties.sv */
`timescale 1ns/1ps

module riscv_core_properties import rv_isa_pkg::*; (
  input logic            clk,
  input logic            rst,
  input logic [XLEN-1:0] pc,
  input logic            dmem_we,
  input logic            halt
);

  // A halted core leaves data memory alone
  no_store_when_halted: assert property (
    @(posedge clk) disable iff (rst) halt |-> !dmem_we
  ) else $error("dmem_we is high while the core is halted");

  pc_frozen_when_halted: assert property (
    @(posedge clk) disable iff (rst) halt |=> $stable(pc)
  ) else $error("pc changed while the core is halted");

  pc_word_aligned: assert property (
    @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
  ) else $error("pc is not word aligned");

  // Only reset leaves the halt state
  halt_sticky: assert property (
    @(posedge clk) disable iff (rst) halt |=> halt
  ) else $error("halt fell without a reset");

endmodule

/* riscv_core.sv */
`timescale 1ns/1ps

module riscv_core import rv_isa_pkg::*, rv_core_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  output logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] insn,
  output logic [XLEN-1:0] dmem_addr,
  output logic [XLEN-1:0] dmem_wdata,
  input  logic [XLEN-1:0] dmem_rdata,
  output logic            dmem_we,
  output logic            halt
);

  logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
  logic [XLEN-1:0]       rs1_data, rs2_data;
  logic [XLEN-1:0]       imm, op_a, op_b;
  logic [XLEN-1:0]       alu_result, pc_plus4, rf_wdata;
  op_a_sel_e             op_a_sel;
  logic                  op_b_imm;
  alu_op_e               alu_op;
  cmp_op_e               cmp_op;
  wb_sel_e               wb_sel;
  pc_sel_e               pc_sel;
  logic                  rf_we, branch, cond, ecall, running;

  insn_decoder insn_decoder_i (
    .insn(insn), .running(running),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr), .imm(imm),
    .op_a_sel(op_a_sel), .op_b_imm(op_b_imm), .alu_op(alu_op), .cmp_op(cmp_op),
    .wb_sel(wb_sel), .rf_we(rf_we), .dmem_we(dmem_we),
    .pc_sel(pc_sel), .branch(branch), .ecall(ecall)
  );

  reg_file reg_file_i (
    .clk(clk), .rst(rst),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rd_addr(rd_addr), .rd_data(rf_wdata), .we(rf_we)
  );

  // Operand selects
  assign op_a = (op_a_sel == OPA_PC) ? pc : (op_a_sel == OPA_ZERO) ? '0 : rs1_data;
  assign op_b = op_b_imm ? imm : rs2_data;

  alu alu_i (
    .a(op_a), .b(op_b), .alu_op(alu_op), .cmp_op(cmp_op),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .result(alu_result), .cond(cond)
  );

  fetch_control #(.RESET_PC(RESET_PC)) fetch_control_i (
    .clk(clk), .rst(rst), .pc_sel(pc_sel), .branch(branch), .cond(cond), .imm(imm),
    .jalr_target(alu_result), .ecall(ecall),
    .pc(pc), .pc_plus4(pc_plus4), .running(running), .halt(halt)
  );

  // Write-back source
  assign rf_wdata = (wb_sel == WB_LOAD) ? dmem_rdata :
                    (wb_sel == WB_PC4)  ? pc_plus4 : alu_result;

  assign dmem_addr  = alu_result; // rs1 + offset
  assign dmem_wdata = rs2_data;

endmodule

/* fetch_control.sv */
`timescale 1ns/1ps

module fetch_control import rv_isa_pkg::*, rv_core_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  pc_sel_e         pc_sel,
  input  logic            branch,
  input  logic            cond,
  input  logic [XLEN-1:0] imm,
  input  logic [XLEN-1:0] jalr_target,
  input  logic            ecall,
  output logic [XLEN-1:0] pc,
  output logic [XLEN-1:0] pc_plus4,
  output logic            running,
  output logic            halt
);

  run_state_e      state;
  logic [XLEN-1:0] pc_rel;  // Branch and JAL target
  logic [XLEN-1:0] pc_next;

  assign pc_plus4 = pc + XLEN'(4);
  assign pc_rel   = pc + imm;

  always_comb begin
    case (pc_sel)
      PC_BRANCH: pc_next = (branch && cond) ? pc_rel : pc_plus4;
      PC_JAL:    pc_next = pc_rel;
      PC_JALR:   pc_next = {jalr_target[XLEN-1:1], 1'b0};
      default:   pc_next = pc_plus4;
    endcase
  end

  // Run/halt FSM, halt is left only through reset
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_RUN;
      pc    <= RESET_PC;
    end else if (state == ST_RUN) begin
      if (ecall) begin
        state <= ST_HALT; // PC stays on the ECALL
      end else begin
        pc <= pc_next;
      end
    end
  end

  assign running = (state == ST_RUN);
  assign halt    = (state == ST_HALT);

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu import rv_isa_pkg::*, rv_core_pkg::*; (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  alu_op_e         alu_op,
  input  cmp_op_e         cmp_op,
  input  logic [XLEN-1:0] rs1_data,
  input  logic [XLEN-1:0] rs2_data,
  output logic [XLEN-1:0] result,
  output logic            cond
);

  logic [4:0] shamt;
  logic       lt_s, lt_u;  // Operand compares for SLT/SLTU
  logic       eq_r, lt_rs, lt_ru; // Register compares for branches

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (alu_op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = a + b;
    endcase
  end

  assign eq_r  = rs1_data == rs2_data;
  assign lt_rs = $signed(rs1_data) < $signed(rs2_data);
  assign lt_ru = rs1_data < rs2_data;

  always_comb begin
    case (cmp_op)
      CMP_EQ:  cond = eq_r;
      CMP_NE:  cond = !eq_r;
      CMP_LT:  cond = lt_rs;
      CMP_GE:  cond = !lt_rs;
      CMP_LTU: cond = lt_ru;
      CMP_GEU: cond = !lt_ru;
      default: cond = 1'b0;
    endcase
  end

endmodule

/* insn_decoder.sv */
`timescale 1ns/1ps

module insn_decoder import rv_isa_pkg::*, rv_core_pkg::*; (
  input  logic [XLEN-1:0]       insn,
  input  logic                  running,
  output logic [REG_ADDR_W-1:0] rs1_addr,
  output logic [REG_ADDR_W-1:0] rs2_addr,
  output logic [REG_ADDR_W-1:0] rd_addr,
  output logic [XLEN-1:0]       imm,
  output op_a_sel_e             op_a_sel,
  output logic                  op_b_imm,
  output alu_op_e               alu_op,
  output cmp_op_e               cmp_op,
  output wb_sel_e               wb_sel,
  output logic                  rf_we,
  output logic                  dmem_we,
  output pc_sel_e               pc_sel,
  output logic                  branch,
  output logic                  ecall
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
  logic            alt;         // funct7 asks for SUB or SRA
  logic            rf_we_d, dmem_we_d, ecall_d;

  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt_op);
    alu_op_e op;
    op = ALU_ADD;
    case (f3)
      F3_ADD:  op = alt_op ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt_op ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      F3_AND:  op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode   = opcode_e'(insn[6:0]);
  assign funct3   = insn[14:12];
  assign funct7   = insn[31:25];
  assign rd_addr  = insn[11:7];
  assign rs1_addr = insn[19:15];
  assign rs2_addr = insn[24:20];
  assign alt      = (funct7 == FUNCT7_ALT);

  // Sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    imm       = imm_i;
    op_a_sel  = OPA_RS1;
    op_b_imm  = 1'b1;
    alu_op    = ALU_ADD; // Address add for loads, stores and JALR
    cmp_op    = CMP_EQ;
    wb_sel    = WB_ALU;
    pc_sel    = PC_SEQ;
    branch    = 1'b0;
    rf_we_d   = 1'b0;
    dmem_we_d = 1'b0;
    ecall_d   = 1'b0;
    case (opcode)
      OP_LUI: begin
        op_a_sel = OPA_ZERO;
        imm      = imm_u;
        rf_we_d  = 1'b1;
      end
      OP_AUIPC: begin
        op_a_sel = OPA_PC;
        imm      = imm_u;
        rf_we_d  = 1'b1;
      end
      OP_JAL: begin
        imm     = imm_j;
        pc_sel  = PC_JAL;
        wb_sel  = WB_PC4;
        rf_we_d = 1'b1;
      end
      OP_JALR: begin
        if (funct3 == F3_JALR) begin
          pc_sel  = PC_JALR; // Target comes out of the ALU
          wb_sel  = WB_PC4;
          rf_we_d = 1'b1;
        end
      end
      OP_BRANCH: begin
        imm    = imm_b;
        branch = 1'b1;
        pc_sel = PC_BRANCH;
        case (funct3)
          F3_BEQ:  cmp_op = CMP_EQ;
          F3_BNE:  cmp_op = CMP_NE;
          F3_BLT:  cmp_op = CMP_LT;
          F3_BGE:  cmp_op = CMP_GE;
          F3_BLTU: cmp_op = CMP_LTU;
          F3_BGEU: cmp_op = CMP_GEU;
          default: begin
            branch = 1'b0;
            pc_sel = PC_SEQ;
          end
        endcase
      end
      OP_LOAD: begin
        wb_sel  = WB_LOAD;
        rf_we_d = (funct3 == F3_WORD); // Word loads only
      end
      OP_STORE: begin
        imm       = imm_s;
        dmem_we_d = (funct3 == F3_WORD);
      end
      OP_IMM: begin
        alu_op = alu_from_funct3(funct3, alt && funct3 == F3_SR);
        if (funct3 == F3_SLL) begin
          rf_we_d = (funct7 == FUNCT7_BASE);
        end else if (funct3 == F3_SR) begin
          rf_we_d = (funct7 == FUNCT7_BASE) || alt;
        end else begin
          rf_we_d = 1'b1;
        end
      end
      OP_REG: begin
        op_b_imm = 1'b0;
        alu_op   = alu_from_funct3(funct3, alt);
        rf_we_d  = (funct7 == FUNCT7_BASE) || (alt && (funct3 == F3_ADD || funct3 == F3_SR));
      end
      OP_SYSTEM: ecall_d = (insn[31:7] == '0);
      default: ; // FENCE and unknown opcodes retire as no-ops
    endcase
  end

  // Nothing writes once the core has halted
  assign rf_we   = rf_we_d && running;
  assign dmem_we = dmem_we_d && running;
  assign ecall   = ecall_d && running;

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file import rv_isa_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [REG_ADDR_W-1:0] rs1_addr,
  input  logic [REG_ADDR_W-1:0] rs2_addr,
  output logic [XLEN-1:0]       rs1_data,
  output logic [XLEN-1:0]       rs2_data,
  input  logic [REG_ADDR_W-1:0] rd_addr,
  input  logic [XLEN-1:0]       rd_data,
  input  logic                  we
);

  // x1..x31 only, x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Combinational read ports
  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if (rs1_addr != '0) begin
      rs1_data = regs[rs1_addr];
    end
    if (rs2_addr != '0) begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

/* rv_core_pkg.sv */
package rv_core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // Branch compare of rs1 against rs2
  typedef enum logic [2:0] {
    CMP_EQ,
    CMP_NE,
    CMP_LT,
    CMP_GE,
    CMP_LTU,
    CMP_GEU
  } cmp_op_e;

  typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;

  typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} op_a_sel_e; // ALU operand a

  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e; // Register write-back source

  typedef enum logic [0:0] {ST_RUN, ST_HALT} run_state_e;

endpackage

/* rv_isa_pkg.sv */
package rv_isa_pkg;

  localparam int XLEN       = 32; // Data and register width
  localparam int REG_ADDR_W = 5;  // Register index width

  // Major opcodes in bits [6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011, // Register-immediate group
    OP_REG    = 7'b0110011, // Register-register group
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // Branch compares
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // ALU group, same codes for OP_IMM and OP_REG
  localparam logic [2:0] F3_ADD  = 3'b000; // ADD and SUB
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // SRL and SRA
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [2:0] F3_JALR = 3'b000;
  localparam logic [2:0] F3_WORD = 3'b010; // LW and SW

  // funct7 field
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // SUB, SRA, SRAI

endpackage
